/* common/sound_pkg.sv */
// note and config structs, register map, sequencer state type for the tone generator
`default_nettype none

package sound_pkg;

	// ----------------------------------------
	// register map, 5-bit byte addresses
	// ----------------------------------------
	localparam logic [4:0] REG_CTRL   = 5'h00;
	localparam logic [4:0] REG_TICK   = 5'h01;
	localparam logic [4:0] REG_STEP   = 5'h02;
	// read only, returns current step index
	localparam logic [4:0] REG_STATUS = 5'h03;
	// note n at NOTE_BASE + 3n: div low, div high, level
	localparam logic [4:0] NOTE_BASE  = 5'h08;

	// one table entry, 24 bits
	typedef struct packed {
		logic [15:0] divider;
		logic [7:0]  level;
	} note_t;

	// host-written configuration
	typedef struct packed {
		logic       enable;
		logic [7:0] tick_div;
		logic [7:0] step_len;
	} sound_cfg_t;

	// play FSM
	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,
		SEQ_LOAD = 2'd1,
		SEQ_PLAY = 2'd2
	} seq_state_t;

	// reset values
	localparam sound_cfg_t CFG_RESET  = '{enable: 1'b0, tick_div: 8'd0, step_len: 8'd0};
	localparam note_t      NOTE_RESET = '{divider: 16'd0, level: 8'd0};

endpackage

`default_nettype wire

/* design/sound_regs.sv */
// wishbone classic slave with control registers and the note table
`default_nettype none
`timescale 1ns/1ps

module sound_regs import sound_pkg::*; #(
	parameter int NOTE_COUNT = 8,
	localparam int IDX_W = $clog2(NOTE_COUNT)
) (
	input  wire              clk,
	input  wire              w_n_reset,
	input  wire              wb_cyc,
	input  wire              wb_stb,
	input  wire              wb_we,
	input  wire  [4:0]       wb_adr,
	input  wire  [7:0]       wb_dat_w,
	input  wire  [IDX_W-1:0] step_idx,
	output logic [7:0]       wb_dat_r,
	output logic             wb_ack,
	output sound_cfg_t       cfg,
	output note_t            note
);
	sound_cfg_t  ff_cfg;
	note_t       ff_table [NOTE_COUNT];
	logic        ff_ack;
	logic [7:0]  ff_dat_r;
	logic        w_req;
	logic        w_wr;
	logic [7:0]  w_rd_data;

	// ----------------------------------------
	// classic handshake
	// ----------------------------------------
	// new request only while ack is low
	assign w_req = wb_cyc & wb_stb & ~ff_ack;
	assign w_wr  = w_req & wb_we;

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_ack   <= 1'b0;
			ff_dat_r <= 8'd0;
		end else begin
			ff_ack <= w_req;
			// read data only alongside ack, zero otherwise
			if (w_req && !wb_we) begin
				ff_dat_r <= w_rd_data;
			end else begin
				ff_dat_r <= 8'd0;
			end
		end
	end

	// ----------------------------------------
	// register writes
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_cfg <= CFG_RESET;
			for (int i = 0; i < NOTE_COUNT; i++) begin
				ff_table[i] <= NOTE_RESET;
			end
		end else if (w_wr) begin
			case (wb_adr)
				REG_CTRL: ff_cfg.enable   <= wb_dat_w[0];
				REG_TICK: ff_cfg.tick_div <= wb_dat_w;
				REG_STEP: ff_cfg.step_len <= wb_dat_w;
				default: begin
					// note bytes, status is read only
					for (int i = 0; i < NOTE_COUNT; i++) begin
						if (wb_adr == 5'(NOTE_BASE + 3 * i)) begin
							ff_table[i].divider[7:0] <= wb_dat_w;
						end
						if (wb_adr == 5'(NOTE_BASE + 3 * i + 1)) begin
							ff_table[i].divider[15:8] <= wb_dat_w;
						end
						if (wb_adr == 5'(NOTE_BASE + 3 * i + 2)) begin
							ff_table[i].level <= wb_dat_w;
						end
					end
				end
			endcase
		end
	end

	// ----------------------------------------
	// read mux
	// ----------------------------------------
	always_comb begin
		w_rd_data = 8'd0;
		case (wb_adr)
			REG_CTRL:   w_rd_data = {7'd0, ff_cfg.enable};
			REG_TICK:   w_rd_data = ff_cfg.tick_div;
			REG_STEP:   w_rd_data = ff_cfg.step_len;
			REG_STATUS: w_rd_data = 8'(step_idx);
			default: begin
				for (int i = 0; i < NOTE_COUNT; i++) begin
					if (wb_adr == 5'(NOTE_BASE + 3 * i)) begin
						w_rd_data = ff_table[i].divider[7:0];
					end
					if (wb_adr == 5'(NOTE_BASE + 3 * i + 1)) begin
						w_rd_data = ff_table[i].divider[15:8];
					end
					if (wb_adr == 5'(NOTE_BASE + 3 * i + 2)) begin
						w_rd_data = ff_table[i].level;
					end
				end
			end
		endcase
	end

	assign wb_ack   = ff_ack;
	assign wb_dat_r = ff_dat_r;
	assign cfg      = ff_cfg;
	// current note straight from the table
	assign note     = ff_table[step_idx];

endmodule

`default_nettype wire

/* design/tone/tone_timer.sv */
// tick prescaler, tone half-period divider and step-length counter
`default_nettype none
`timescale 1ns/1ps

module tone_timer import sound_pkg::*; (
	input  wire        clk,
	input  wire        w_n_reset,
	input  sound_cfg_t cfg,
	input  note_t      note,
	input  wire        restart,
	output logic       tone_flip,
	output logic       step_end
);
	logic [7:0]  ff_pre_cnt;
	logic [15:0] ff_tone_cnt;
	logic [7:0]  ff_step_cnt;
	logic        ff_tone_flip;
	logic        ff_step_end;
	logic        w_hold;
	logic        w_tick;
	logic        w_tone_zero;
	logic        w_step_zero;

	// held in reload while disabled or restarted
	assign w_hold      = restart | ~cfg.enable;
	assign w_tick      = (ff_pre_cnt == 8'd0);
	assign w_tone_zero = (ff_tone_cnt == 16'd0);
	assign w_step_zero = (ff_step_cnt == 8'd0);

	// ----------------------------------------
	// prescaler, tick every tick_div+1 clocks
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_pre_cnt <= 8'd0;
		end else if (w_hold || w_tick) begin
			ff_pre_cnt <= cfg.tick_div;
		end else begin
			ff_pre_cnt <= ff_pre_cnt - 8'd1;
		end
	end

	// ----------------------------------------
	// tone and step down-counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_tone_cnt <= 16'd0;
			ff_step_cnt <= 8'd0;
		end else if (w_hold) begin
			// full periods from a new start or step
			ff_tone_cnt <= note.divider;
			ff_step_cnt <= cfg.step_len;
		end else if (w_tick) begin
			ff_tone_cnt <= w_tone_zero ? note.divider : ff_tone_cnt - 16'd1;
			ff_step_cnt <= w_step_zero ? cfg.step_len : ff_step_cnt - 8'd1;
		end
	end

	// strobes, one clock, qualified by tick
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_tone_flip <= 1'b0;
			ff_step_end  <= 1'b0;
		end else begin
			ff_tone_flip <= ~w_hold & w_tick & w_tone_zero;
			ff_step_end  <= ~w_hold & w_tick & w_step_zero;
		end
	end

	assign tone_flip = ff_tone_flip;
	assign step_end  = ff_step_end;

endmodule

`default_nettype wire

/* design/tone/tone_sequencer.sv */
// play FSM with step index and square-wave sample register
`default_nettype none
`timescale 1ns/1ps

module tone_sequencer import sound_pkg::*; #(
	parameter int NOTE_COUNT = 8,
	localparam int IDX_W = $clog2(NOTE_COUNT)
) (
	input  wire              clk,
	input  wire              w_n_reset,
	input  sound_cfg_t       cfg,
	input  note_t            note,
	input  wire              tone_flip,
	input  wire              step_end,
	output logic [IDX_W-1:0] step_idx,
	output logic             restart,
	output logic [7:0]       sample
);
	seq_state_t       ff_state;
	logic [IDX_W-1:0] ff_step_idx;
	logic [7:0]       ff_sample;
	logic             ff_restart;
	logic             w_last_step;

	// wrap point of the note loop
	assign w_last_step = (ff_step_idx == IDX_W'(NOTE_COUNT - 1));

	// ----------------------------------------
	// play FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_state    <= SEQ_IDLE;
			ff_step_idx <= '0;
			ff_sample   <= 8'd0;
			ff_restart  <= 1'b0;
		end else begin
			// restart is a single-cycle pulse
			ff_restart <= 1'b0;
			case (ff_state)
				SEQ_IDLE: begin
					ff_step_idx <= '0;
					ff_sample   <= 8'd0;
					// enable rising, restart visible in load
					if (cfg.enable) begin
						ff_state   <= SEQ_LOAD;
						ff_restart <= 1'b1;
					end
				end
				SEQ_LOAD: begin
					// counters reloaded this cycle
					ff_state <= cfg.enable ? SEQ_PLAY : SEQ_IDLE;
				end
				SEQ_PLAY: begin
					if (!cfg.enable) begin
						ff_state    <= SEQ_IDLE;
						ff_step_idx <= '0;
						ff_sample   <= 8'd0;
					end else if (step_end) begin
						// next note, silent until its first flip
						ff_step_idx <= w_last_step ? '0 : ff_step_idx + 1'b1;
						ff_sample   <= 8'd0;
						ff_restart  <= 1'b1;
					end else if (tone_flip && !ff_restart) begin
						// flips during restart belong to the old note
						ff_sample <= (ff_sample == 8'd0) ? note.level : 8'd0;
					end
				end
				default: begin
					ff_state <= SEQ_IDLE;
				end
			endcase
		end
	end

	assign step_idx = ff_step_idx;
	assign restart  = ff_restart;
	assign sample   = ff_sample;

endmodule

`default_nettype wire

/* design/tone/pwm_dac.sv */
// free-running PWM counter with registered compare
`default_nettype none
`timescale 1ns/1ps

module pwm_dac #(
	parameter int PWM_WIDTH = 8
) (
	input  wire        clk,
	input  wire        w_n_reset,
	input  wire  [7:0] sample,
	output logic       pwm_wave
);
	logic [PWM_WIDTH-1:0] ff_cnt;
	logic                 ff_pwm;

	// ----------------------------------------
	// counter wraps every 2^PWM_WIDTH clocks
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_cnt <= '0;
		end else begin
			ff_cnt <= ff_cnt + 1'b1;
		end
	end

	// high for sample clocks per period
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_pwm <= 1'b0;
		end else begin
			ff_pwm <= (ff_cnt < PWM_WIDTH'(sample));
		end
	end

	// to the RC filter
	assign pwm_wave = ff_pwm;

endmodule

`default_nettype wire

/* design/sound_cart_top.sv */
// tone generator top: register block, timer, sequencer and PWM DAC
`default_nettype none
`timescale 1ns/1ps

module sound_cart_top import sound_pkg::*; #(
	parameter int NOTE_COUNT = 8,
	parameter int PWM_WIDTH  = 8
) (
	input  wire        clk,
	input  wire        w_n_reset,
	input  wire        wb_cyc,
	input  wire        wb_stb,
	input  wire        wb_we,
	input  wire  [4:0] wb_adr,
	input  wire  [7:0] wb_dat_w,
	output logic [7:0] wb_dat_r,
	output logic       wb_ack,
	output logic [7:0] sample,
	output logic       pwm_wave
);
	localparam int IDX_W = $clog2(NOTE_COUNT);

	sound_cfg_t       w_cfg;
	note_t            w_note;
	logic [IDX_W-1:0] w_step_idx;
	logic             w_restart;
	logic             w_tone_flip;
	logic             w_step_end;

	// ----------------------------------------
	// host registers and note table
	// ----------------------------------------
	sound_regs #(
		.NOTE_COUNT (NOTE_COUNT)
	) u_regs (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.step_idx  (w_step_idx),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.cfg       (w_cfg),
		.note      (w_note)
	);

	// ----------------------------------------
	// tone path
	// ----------------------------------------
	tone_timer u_timer (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.cfg       (w_cfg),
		.note      (w_note),
		.restart   (w_restart),
		.tone_flip (w_tone_flip),
		.step_end  (w_step_end)
	);

	tone_sequencer #(
		.NOTE_COUNT (NOTE_COUNT)
	) u_sequencer (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.cfg       (w_cfg),
		.note      (w_note),
		.tone_flip (w_tone_flip),
		.step_end  (w_step_end),
		.step_idx  (w_step_idx),
		.restart   (w_restart),
		.sample    (sample)
	);

	// sample also goes out as PWM
	pwm_dac #(
		.PWM_WIDTH (PWM_WIDTH)
	) u_pwm (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.sample    (sample),
		.pwm_wave  (pwm_wave)
	);

endmodule

`default_nettype wire

/* dv/sound_props.sv */
// wishbone handshake assertions for the register block
`default_nettype none
`timescale 1ns/1ps

module sound_props (
	input wire clk,
	input wire w_n_reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack
);
	// ack only answers a cycle with cyc and stb high
	ack_after_req: assert property (@(posedge clk) disable iff (!w_n_reset)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("ack without cyc and stb in the previous cycle");

	// single-cycle ack
	ack_one_cycle: assert property (@(posedge clk) disable iff (!w_n_reset)
		wb_ack |=> !wb_ack)
		else $error("ack high two cycles in a row");

	// synchronous reset clears ack
	ack_low_in_reset: assert property (@(posedge clk) !w_n_reset |=> !wb_ack)
		else $error("ack high after reset");

endmodule

`default_nettype wire

/* dv/sound_checker.sv */
// monitor of sample and pwm_wave with read, ack, play and PWM checks
`default_nettype none
`timescale 1ns/1ps

module sound_checker #(
	parameter int NOTE_COUNT = 8
) (
	input wire       clk,
	input wire       w_n_reset,
	input wire [7:0] sample,
	input wire       pwm_wave
);
	int unsigned read_errs, ack_errs, play_errs, pwm_errs;
	logic [15:0] div_tab [NOTE_COUNT];
	logic [7:0]  lvl_tab [NOTE_COUNT];
	int          tick_div, step_len, idx;
	bit          playing, silent;
	int unsigned cyc, last_edge, pending, step_start, steps_seen;
	logic [7:0]  prev_s, run_val;
	int unsigned run_len, high_cnt, hist_ptr;
	bit          hist [256];

	function automatic int half_period(input int n);
		return (int'(div_tab[n]) + 1) * (tick_div + 1);
	endfunction

	function automatic int unsigned total_errors();
		return read_errs + ack_errs + play_errs + pwm_errs;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("** Error at %0t: %s", $time, msg);
	endtask

	// ----------------------------------------
	// configuration mirror from the testbench
	// ----------------------------------------
	task automatic set_tick(input logic [7:0] v);
		tick_div = int'(v);
	endtask

	task automatic set_step(input logic [7:0] v);
		step_len = int'(v);
	endtask

	task automatic set_divider_byte(input int n, input bit hi, input logic [7:0] v);
		if (hi) div_tab[n][15:8] = v;
		else div_tab[n][7:0] = v;
	endtask

	task automatic set_silent(input bit on);
		silent = on;
	endtask

	task automatic start_play(input logic [7:0][7:0] levels);
		for (int n = 0; n < NOTE_COUNT; n++) begin
			lvl_tab[n] = levels[n];
		end
		idx = -1;
		steps_seen = 0;
		pending = 0;
		playing = 1;
	endtask

	task automatic end_play();
		playing = 0;
		if (steps_seen == 0) begin
			play_errs++;
			report_mismatch("no note heard during the play window");
		end
	endtask

	task automatic check_read(input logic [4:0] adr, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			read_errs++;
			report_mismatch($sformatf("read 0x%02h returned 0x%02h, expected 0x%02h", adr, got, exp));
		end
	endtask

	// latency in cycles from strobe, ack level one cycle later
	task automatic check_ack(input int latency, input logic held);
		if (latency != 1 || held !== 1'b0) begin
			ack_errs++;
			report_mismatch($sformatf("ack after %0d cycles, next cycle %b", latency, held));
		end
	endtask

	// ----------------------------------------
	// sample edge tracking during play
	// ----------------------------------------
	task automatic track_edge();
		int unsigned gap;
		int nxt, hp, expect_span, tol, span;
		gap = cyc - last_edge;
		last_edge = cyc;
		if (sample == 8'd0) begin
			// judged once the next rise shows the same note
			pending = gap;
		end else if (idx >= 0 && sample == lvl_tab[idx]) begin
			hp = half_period(idx);
			if (pending != hp || gap != hp) begin
				play_errs++;
				report_mismatch($sformatf("note %0d half periods %0d/%0d, expected %0d",
					idx, pending, gap, hp));
			end
		end else begin
			nxt = (idx < 0) ? 0 : (idx + 1) % NOTE_COUNT;
			if (sample != lvl_tab[nxt]) begin
				play_errs++;
				report_mismatch($sformatf("level 0x%02h, expected 0x%02h of note %0d",
					sample, lvl_tab[nxt], nxt));
			end else if (idx >= 0) begin
				// first rises sit one half period into each step
				span = int'(cyc - step_start);
				expect_span = (step_len + 1) * (tick_div + 1) + half_period(nxt) - half_period(idx);
				tol = half_period(idx) + 2;
				if (span > expect_span + tol || span + tol < expect_span) begin
					play_errs++;
					report_mismatch($sformatf("step %0d lasted %0d clocks, expected %0d",
						idx, span, expect_span));
				end
			end
			idx = nxt;
			step_start = cyc;
			steps_seen++;
			pending = 0;
		end
	endtask

	// ----------------------------------------
	// per-clock monitor, outputs stable at negedge
	// ----------------------------------------
	always @(negedge clk) begin
		if (!w_n_reset) begin
			cyc = 0;
			prev_s = 8'd0;
			run_len = 0;
			high_cnt = 0;
			hist_ptr = 0;
			for (int i = 0; i < 256; i++) begin
				hist[i] = 0;
			end
			// note table comes out of reset as zeros
			for (int n = 0; n < NOTE_COUNT; n++) begin
				div_tab[n] = 16'd0;
			end
		end else begin
			cyc++;
			// pwm now reflects the sample of one clock ago
			if (prev_s == run_val) run_len++;
			else begin
				run_val = prev_s;
				run_len = 1;
			end
			high_cnt = high_cnt - int'(hist[hist_ptr]) + int'(pwm_wave);
			hist[hist_ptr] = pwm_wave;
			hist_ptr = (hist_ptr + 1) % 256;
			if (run_len >= 256 && high_cnt != int'(run_val)) begin
				pwm_errs++;
				report_mismatch($sformatf("pwm high %0d of 256 clocks, sample 0x%02h",
					high_cnt, run_val));
			end
			if (silent && sample != 8'd0) begin
				play_errs++;
				report_mismatch($sformatf("sample 0x%02h while disabled", sample));
			end
			if (playing && sample != prev_s) begin
				track_edge();
			end
			prev_s = sample;
		end
	end

endmodule

`default_nettype wire

/* dv/tb_sound_cart.sv */
// testbench top: clock, reset, data file reader, wishbone driver, watchdog, report
`default_nettype none
`timescale 1ns/1ps

module tb_sound_cart import sound_pkg::*; ();
	localparam int NOTE_COUNT = 8;

	// one line of the data file
	typedef struct packed {
		logic [7:0]      kind;
		logic [15:0]     arg_a;
		logic [7:0]      arg_b;
		logic [7:0][7:0] levels;
	} test_rec_t;

	logic        clk;
	logic        w_n_reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [4:0]  wb_adr;
	logic [7:0]  wb_dat_w;
	wire  [7:0]  wb_dat_r;
	wire         wb_ack;
	wire  [7:0]  sample;
	wire         pwm_wave;
	test_rec_t   recs [$];
	int unsigned limit_cycles;
	int unsigned bad_recs;

	sound_cart_top #(
		.NOTE_COUNT (NOTE_COUNT),
		.PWM_WIDTH  (8)
	) i_dut (
		.clk      (clk),
		.w_n_reset(w_n_reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.sample   (sample),
		.pwm_wave (pwm_wave)
	);

	sound_checker #(.NOTE_COUNT(NOTE_COUNT)) i_chk (
		.clk      (clk),
		.w_n_reset(w_n_reset),
		.sample   (sample),
		.pwm_wave (pwm_wave)
	);

	bind sound_regs sound_props i_props (
		.clk(clk), .w_n_reset(w_n_reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------
	// data file, watchdog budget
	// ----------------------------------------
	task automatic load_records(output bit opened);
		int fd, n;
		string line;
		logic [7:0] kind, b;
		int unsigned a;
		logic [7:0] lv [8];
		test_rec_t rec;
		fd = $fopen("dv/sound_testdata.txt", "r");
		opened = (fd != 0);
		if (opened) begin
			limit_cycles = 20;
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin
					rec = '0;
					n = $sscanf(line, "%c", kind);
					if (kind == "P") begin
						n = $sscanf(line, "%c %d %h %h %h %h %h %h %h %h", kind, a,
							lv[0], lv[1], lv[2], lv[3], lv[4], lv[5], lv[6], lv[7]);
						for (int k = 0; k < 8; k++) begin
							rec.levels[k] = lv[k];
						end
						limit_cycles += 2 * a;
					end else begin
						n = $sscanf(line, "%c %h %h", kind, a, b);
						rec.arg_b = b;
						limit_cycles += 200;
					end
					rec.kind = kind;
					rec.arg_a = a[15:0];
					recs.push_back(rec);
				end
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------
	// wishbone classic host, driven at negedge
	// ----------------------------------------
	task automatic bus_access(input logic we, input logic [4:0] adr, input logic [7:0] wdat,
		output logic [7:0] rdat);
		int wait_cyc;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		wait_cyc = 0;
		do begin
			@(negedge clk);
			wait_cyc++;
		end while (!wb_ack && wait_cyc < 16);
		// data valid only alongside ack
		rdat = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
		i_chk.check_ack(wait_cyc, wb_ack);
	endtask

	// keep the checker's view of tick, step and dividers current
	task automatic mirror_write(input logic [4:0] adr, input logic [7:0] data);
		int off;
		off = int'(adr) - int'(NOTE_BASE);
		if (adr == REG_TICK) i_chk.set_tick(data);
		else if (adr == REG_STEP) i_chk.set_step(data);
		else if (off >= 0 && off % 3 < 2) i_chk.set_divider_byte(off / 3, off % 3 == 1, data);
	endtask

	task automatic run_record(input test_rec_t rec);
		logic [7:0] rdat;
		logic ctrl;
		ctrl = (rec.arg_a[4:0] == REG_CTRL);
		case (rec.kind)
			"W": begin
				if (ctrl && rec.arg_b[0]) i_chk.set_silent(1'b0);
				bus_access(1'b1, rec.arg_a[4:0], rec.arg_b, rdat);
				mirror_write(rec.arg_a[4:0], rec.arg_b);
				// two cycles past ack, sample must be quiet
				if (ctrl && !rec.arg_b[0]) i_chk.set_silent(1'b1);
			end
			"R": begin
				bus_access(1'b0, rec.arg_a[4:0], 8'h00, rdat);
				i_chk.check_read(rec.arg_a[4:0], rdat, rec.arg_b);
			end
			"P": begin
				i_chk.start_play(rec.levels);
				repeat (rec.arg_a) @(negedge clk);
				i_chk.end_play();
			end
			default: begin
				bad_recs++;
				$display("unknown record kind %c in the data file", rec.kind);
			end
		endcase
	endtask

	// ----------------------------------------
	// main sequence and report
	// ----------------------------------------
	initial begin
		bit file_ok;
		w_n_reset = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 5'd0;
		wb_dat_w = 8'd0;
		load_records(file_ok);
		if (!file_ok) begin
			$display("cannot open the data file dv/sound_testdata.txt");
			$display("Testbench failed");
		end else begin
			repeat (5) @(negedge clk);
			w_n_reset = 1'b1;
			@(negedge clk);
			foreach (recs[i]) begin
				run_record(recs[i]);
			end
			@(negedge clk);
			$display("errors: read %0d, ack %0d, play %0d, pwm %0d, data file %0d",
				i_chk.read_errs, i_chk.ack_errs, i_chk.play_errs, i_chk.pwm_errs, bad_recs);
			if (i_chk.total_errors() + bad_recs == 0) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
		end
		$finish;
	end

	// watchdog, budget set once the file is read
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/sound_testdata.txt */
# W addr data / R addr expected, all hex
# P clocks (decimal) then levels of notes 0..7 (hex)
R 00 00
R 01 00
R 02 00
R 03 00
R 08 00
R 1f 00
W 01 01
W 02 0f
W 0b 02
W 0e 01
W 0a 10
W 0d 20
W 10 30
W 13 40
W 16 50
W 19 60
W 1c 70
W 1f 80
R 01 01
R 02 0f
R 0b 02
R 1f 80
R 03 00
W 00 01
R 00 01
P 400 10 20 30 40 50 60 70 80
W 00 00
R 03 00
W 01 0f
W 02 3f
W 08 11
W 00 01
P 1600 10 20 30 40 50 60 70 80
W 00 00
R 03 00
R 08 11

/* compile.f */
common/sound_pkg.sv
design/sound_regs.sv
design/tone/tone_timer.sv
design/tone/tone_sequencer.sv
design/tone/pwm_dac.sv
design/sound_cart_top.sv
dv/sound_props.sv
dv/sound_checker.sv
dv/tb_sound_cart.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_sound_cart
FILELIST  ?= compile.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
